// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mbus_ctrl_wrapper
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
SRCS      ?= $(wildcard *.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ctrl_channel_filter.sv ====
module ctrl_channel_filter (
	input  logic       CLK_EXT,
	input  logic       RESETn_local,
	input  logic       host_ack,
	output logic       host_req,
	mbus_rx_if.filter  rx
);

	logic ctrl_match;
	logic ctrl_ack; // Local acknowledge for absorbed broadcasts.

	assign ctrl_match = rx.rx_broadcast &&
		(rx.rx_addr[mbus_pkg::FUNC_WIDTH-1:0] == mbus_pkg::CHANNEL_CTRL);

	assign host_req = ctrl_match ? 1'b0 : rx.rx_req;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
			ctrl_ack <= 1'b0;
		else
		begin
			if (ctrl_match && rx.rx_req)
				ctrl_ack <= 1'b1;
			if (ctrl_ack && !rx.rx_req)
				ctrl_ack <= 1'b0; // Request gone.
		end
	end

	assign rx.rx_ack = host_ack | ctrl_ack;

	// Absorbed request stays hidden while the node holds it.
	a_ctrl_hidden: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		(rx.rx_req && ctrl_match) |=> !host_req);

endmodule

// ==== layer_power_seq.sv ====
module layer_power_seq (
	input  logic        CLK_EXT,
	input  logic        RESETn_local,
	input  logic        wakeup_proc,
	mbus_power_if.sink  bus_pwr,
	output logic        power_on,
	output logic        release_clk,
	output logic        release_rst,
	output logic        release_iso
);

	typedef enum logic [2:0] {OFF, PWR, CLK, ISO, ON} seq_state_t;

	seq_state_t state;
	logic seq_power_on;
	logic seq_release_clk;
	logic seq_release_iso;
	logic seq_release_rst;

	// One line more per falling edge.
	always_ff @(negedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
			state <= OFF;
		else
		begin
			case (state)
				OFF: if (wakeup_proc) state <= PWR;
				PWR: state <= CLK;
				CLK: state <= ISO;
				ISO: state <= ON;
				ON: if (!wakeup_proc) state <= OFF;
				default: state <= OFF;
			endcase
		end
	end

	assign seq_power_on = (state != OFF) ? mbus_pkg::IO_RELEASE : mbus_pkg::IO_HOLD;
	assign seq_release_clk = (state == CLK || state == ISO || state == ON) ?
		mbus_pkg::IO_RELEASE : mbus_pkg::IO_HOLD;
	assign seq_release_iso = (state == ISO || state == ON) ?
		mbus_pkg::IO_RELEASE : mbus_pkg::IO_HOLD;
	assign seq_release_rst = (state == ON) ? mbus_pkg::IO_RELEASE : mbus_pkg::IO_HOLD;

	// Either source may release a line.
	assign power_on = seq_power_on | bus_pwr.power_on;
	assign release_clk = seq_release_clk | bus_pwr.release_clk;
	assign release_iso = seq_release_iso | bus_pwr.release_iso;
	assign release_rst = seq_release_rst | bus_pwr.release_rst;

endmodule

// ==== mbus_ctrl.sv ====
module mbus_ctrl (
	input  logic              CLK_EXT,
	input  logic              RESETn_local,
	input  logic              din,
	input  mbus_pkg::thresh_t threshold,
	output logic              clkout,
	mbus_phy_if.ctrl          phy
);

	typedef enum logic [1:0] {IDLE, CLOCKING, DONE} state_t;

	state_t state;
	logic din_s1;
	logic din_s2;
	logic din_prev;
	logic [5:0] bit_cnt; // Bus clock rises, start bit included.
	mbus_pkg::thresh_t wd_cnt; // Strobes seen in this frame.
	logic wd_fire;

	assign wd_fire = phy.bit_strobe && (wd_cnt == threshold) &&
		(wd_cnt < mbus_pkg::thresh_t'(mbus_pkg::FRAME_BITS));

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state <= IDLE;
			din_s1 <= 1'b1;
			din_s2 <= 1'b1;
			din_prev <= 1'b1;
			clkout <= 1'b0;
			bit_cnt <= '0;
			wd_cnt <= '0;
			phy.bit_strobe <= 1'b0;
			phy.frame_start <= 1'b0;
			phy.frame_end <= 1'b0;
			phy.frame_abort <= 1'b0;
		end
		else
		begin
			din_s1 <= din;
			din_s2 <= din_s1;
			din_prev <= din_s2;
			phy.bit_strobe <= 1'b0;
			phy.frame_start <= 1'b0;
			phy.frame_end <= 1'b0;
			phy.frame_abort <= 1'b0;
			case (state)
				IDLE:
				begin
					// Falling ring data is the start bit.
					if (din_prev && !din_s2)
					begin
						state <= CLOCKING;
						clkout <= 1'b1; // Start bit clock, no strobe.
						bit_cnt <= 6'd1;
						wd_cnt <= '0;
						phy.frame_start <= 1'b1;
					end
				end
				CLOCKING:
				begin
					if (wd_fire)
					begin
						clkout <= 1'b0;
						phy.frame_abort <= 1'b1;
						state <= IDLE;
					end
					else if (clkout)
					begin
						clkout <= 1'b0;
						if (bit_cnt == 6'(mbus_pkg::FRAME_BITS + 1))
						begin
							phy.frame_end <= 1'b1;
							state <= DONE;
						end
					end
					else
					begin
						clkout <= 1'b1;
						phy.bit_strobe <= 1'b1;
						bit_cnt <= bit_cnt + 6'd1;
						wd_cnt <= wd_cnt + 1'b1;
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	a_end_abort_excl: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		!(phy.frame_end && phy.frame_abort));

endmodule

// ==== mbus_ctrl_wrapper.sv ====
module mbus_ctrl_wrapper #(
	parameter logic [3:0] NODE_PREFIX = 4'h5
) (
	input  logic              CLK_EXT,
	input  logic              RESETn_local,
	input  logic              release_rst_from_sleep_ctrl,
	input  logic              clkin,
	output logic              clkout,
	input  logic              din,
	output logic              dout,
	output mbus_pkg::addr_t   rx_addr,
	output mbus_pkg::data_t   rx_data,
	output logic              rx_req,
	input  logic              rx_ack,
	output logic              rx_broadcast,
	output logic              rx_fail,
	input  mbus_pkg::thresh_t threshold,
	input  logic              wakeup_proc,
	output logic              power_on_to_layer_ctrl,
	output logic              release_clk_to_layer_ctrl,
	output logic              release_rst_to_layer_ctrl,
	output logic              release_iso_to_layer_ctrl,
	output logic              sleep_request_to_sleep_ctrl
);

	logic resetn_gated;
	logic ctrl_clk;
	logic node_clkin;

	mbus_phy_if phy_bus ();
	mbus_rx_if rx_bus ();
	mbus_power_if pwr_bus ();

	assign resetn_gated = RESETn_local & ~release_rst_from_sleep_ctrl; // Held while asleep.

	// Ring clock passes through while the controller is idle and low.
	assign node_clkin = ctrl_clk | clkin;

	assign rx_addr = rx_bus.rx_addr;
	assign rx_data = rx_bus.rx_data;
	assign rx_broadcast = rx_bus.rx_broadcast;

	mbus_ctrl u_ctrl (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (resetn_gated),
		.din          (din),
		.threshold    (threshold),
		.clkout       (ctrl_clk),
		.phy          (phy_bus.ctrl)
	);

	mbus_node #(.NODE_PREFIX(NODE_PREFIX)) u_node (
		.CLK_EXT       (CLK_EXT),
		.RESETn_local  (resetn_gated),
		.clkin         (node_clkin),
		.din           (din),
		.clkout        (clkout),
		.dout          (dout),
		.rx_fail       (rx_fail),
		.sleep_request (sleep_request_to_sleep_ctrl),
		.phy           (phy_bus.node),
		.rx            (rx_bus.node),
		.pwr           (pwr_bus.src)
	);

	ctrl_channel_filter u_filter (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (resetn_gated),
		.host_ack     (rx_ack),
		.host_req     (rx_req),
		.rx           (rx_bus.filter)
	);

	layer_power_seq u_power_seq (
		.CLK_EXT      (CLK_EXT),
		.RESETn_local (resetn_gated),
		.wakeup_proc  (wakeup_proc),
		.bus_pwr      (pwr_bus.sink),
		.power_on     (power_on_to_layer_ctrl),
		.release_clk  (release_clk_to_layer_ctrl),
		.release_rst  (release_rst_to_layer_ctrl),
		.release_iso  (release_iso_to_layer_ctrl)
	);

endmodule

// ==== mbus_if.sv ====
interface mbus_phy_if;
	logic bit_strobe;
	logic frame_start;
	logic frame_end;
	logic frame_abort;

	modport ctrl (output bit_strobe, output frame_start, output frame_end, output frame_abort);
	modport node (input bit_strobe, input frame_start, input frame_end, input frame_abort);
endinterface

interface mbus_rx_if;
	mbus_pkg::addr_t rx_addr;
	mbus_pkg::data_t rx_data;
	logic rx_req;
	logic rx_broadcast;
	logic rx_ack;

	modport node (output rx_addr, output rx_data, output rx_req, output rx_broadcast,
		input rx_ack);
	modport filter (input rx_addr, input rx_req, input rx_broadcast, output rx_ack);
endinterface

interface mbus_power_if;
	logic power_on;
	logic release_clk;
	logic release_rst;
	logic release_iso;

	modport src (output power_on, output release_clk, output release_rst, output release_iso);
	modport sink (input power_on, input release_clk, input release_rst, input release_iso);
endinterface

// ==== mbus_node.sv ====
module mbus_node #(
	parameter logic [3:0] NODE_PREFIX = 4'h5
) (
	input  logic         CLK_EXT,
	input  logic         RESETn_local,
	input  logic         clkin,
	input  logic         din,
	output logic         clkout,
	output logic         dout,
	output logic         rx_fail,
	output logic         sleep_request,
	mbus_phy_if.node     phy,
	mbus_rx_if.node      rx,
	mbus_power_if.src    pwr
);

	logic [mbus_pkg::FRAME_BITS-1:0] shift_reg;
	mbus_pkg::addr_t frame_addr;
	mbus_pkg::data_t frame_data;
	logic [3:0] frame_prefix;
	logic frame_bcast;
	logic frame_match;
	logic ctrl_cmd;
	logic store;

	assign frame_addr = shift_reg[mbus_pkg::FRAME_BITS-1:mbus_pkg::DATA_WIDTH];
	assign frame_data = shift_reg[mbus_pkg::DATA_WIDTH-1:0];
	assign frame_prefix = frame_addr[mbus_pkg::ADDR_WIDTH-1:mbus_pkg::FUNC_WIDTH];
	assign frame_bcast = (frame_prefix == 4'h0);
	assign frame_match = frame_bcast || (frame_prefix == NODE_PREFIX);
	assign ctrl_cmd = frame_bcast &&
		(frame_addr[mbus_pkg::FUNC_WIDTH-1:0] == mbus_pkg::CHANNEL_CTRL);
	assign store = phy.frame_end && frame_match && !rx.rx_req; // Held frame wins.

	assign clkout = clkin; // Ring clock forwarded.

	// Address first, MSB first.
	always_ff @(posedge CLK_EXT)
	begin
		if (phy.frame_start)
			shift_reg <= '0;
		else if (phy.bit_strobe)
			shift_reg <= {shift_reg[mbus_pkg::FRAME_BITS-2:0], din};
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (store)
		begin
			rx.rx_addr <= frame_addr;
			rx.rx_data <= frame_data;
			rx.rx_broadcast <= frame_bcast;
		end
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			rx.rx_req <= 1'b0;
			rx_fail <= 1'b0;
			sleep_request <= 1'b0;
			dout <= 1'b1;
			pwr.power_on <= mbus_pkg::IO_HOLD;
			pwr.release_clk <= mbus_pkg::IO_HOLD;
			pwr.release_rst <= mbus_pkg::IO_HOLD;
			pwr.release_iso <= mbus_pkg::IO_HOLD;
		end
		else
		begin
			dout <= din; // Ring repeater.
			rx_fail <= 1'b0;
			sleep_request <= 1'b0;
			if (rx.rx_req && rx.rx_ack)
				rx.rx_req <= 1'b0;
			if (phy.frame_abort)
				rx_fail <= 1'b1;
			if (phy.frame_end)
			begin
				if (rx.rx_req)
					rx_fail <= 1'b1; // Overrun.
				else if (frame_match)
					rx.rx_req <= 1'b1;
			end
			// Bus power commands.
			if (phy.frame_end && ctrl_cmd && (frame_data[1:0] == mbus_pkg::CMD_WAKE))
			begin
				pwr.power_on <= mbus_pkg::IO_RELEASE;
				pwr.release_clk <= mbus_pkg::IO_RELEASE;
				pwr.release_rst <= mbus_pkg::IO_RELEASE;
				pwr.release_iso <= mbus_pkg::IO_RELEASE;
			end
			if (phy.frame_end && ctrl_cmd && (frame_data[1:0] == mbus_pkg::CMD_SLEEP))
			begin
				pwr.power_on <= mbus_pkg::IO_HOLD;
				pwr.release_clk <= mbus_pkg::IO_HOLD;
				pwr.release_rst <= mbus_pkg::IO_HOLD;
				pwr.release_iso <= mbus_pkg::IO_HOLD;
				sleep_request <= 1'b1;
			end
		end
	end

	a_rx_stable: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		rx.rx_req |=> !rx.rx_req || ($stable(rx.rx_addr) && $stable(rx.rx_data)));

endmodule

// ==== mbus_pkg.sv ====
package mbus_pkg;

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int FUNC_WIDTH = 4;
	localparam int FRAME_BITS = ADDR_WIDTH + DATA_WIDTH; // Bits after the start bit.

	// Address is prefix in the upper nibble, function in the lower.
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [FUNC_WIDTH-1:0] func_t;
	typedef logic [7:0] thresh_t; // Watchdog limit in bus bits.

	localparam func_t CHANNEL_CTRL = 4'd0;

	// Low payload bits of a control broadcast.
	localparam logic [1:0] CMD_WAKE = 2'd1;
	localparam logic [1:0] CMD_SLEEP = 2'd2;

	// Power control line levels.
	localparam logic IO_HOLD = 1'b0;
	localparam logic IO_RELEASE = 1'b1;

endpackage

// ==== tb_mbus_ctrl_wrapper.sv ====
module tb_mbus_ctrl_wrapper;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [3:0] PREFIX = 4'h5;
	localparam int WAIT_LIMIT = 200;

	typedef struct packed {
		logic visible;
		logic bcast;
		logic wake;
		logic sleep;
	} expect_t;

	logic CLK_EXT = 1'b0;
	logic RESETn_local;
	logic release_rst_from_sleep_ctrl;
	logic clkin;
	logic din;
	logic rx_ack;
	logic wakeup_proc;
	mbus_pkg::thresh_t threshold;
	logic clkout;
	logic dout;
	mbus_pkg::addr_t rx_addr;
	mbus_pkg::data_t rx_data;
	logic rx_req;
	logic rx_broadcast;
	logic rx_fail;
	logic power_on_to_layer_ctrl;
	logic release_clk_to_layer_ctrl;
	logic release_rst_to_layer_ctrl;
	logic release_iso_to_layer_ctrl;
	logic sleep_request_to_sleep_ctrl;
	logic [3:0] layer_lines;

	logic [40:0] exp_q[$]; // {broadcast, addr, data} per host frame.
	logic [40:0] exp_frame;
	logic hold_ack;
	logic req_seen;
	int fail_pulses;
	int sleep_pulses;
	integer seed;
	string test_name;

	assign layer_lines = {power_on_to_layer_ctrl, release_clk_to_layer_ctrl,
		release_iso_to_layer_ctrl, release_rst_to_layer_ctrl};

	mbus_ctrl_wrapper #(.NODE_PREFIX(PREFIX)) u_dut (.*);

	always #50 CLK_EXT = ~CLK_EXT;

	task automatic report_mismatch(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		$display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
		$display("tests failed");
		$fatal(1, "check failed in %s", test_name);
	endtask

	task automatic report_error(input string msg);
		$display("[ERROR] %s: %s", test_name, msg);
		$display("tests failed");
		$fatal(1, "check failed in %s", test_name);
	endtask

	// Expected host view and power effect of one frame.
	function automatic expect_t model_frame(input mbus_pkg::addr_t addr,
		input mbus_pkg::data_t data);
		expect_t e;
		logic bcast;
		logic ctrl;
		bcast = (addr[7:4] == 4'h0);
		ctrl = bcast && (addr[3:0] == 4'h0);
		e.visible = (bcast || addr[7:4] == PREFIX) && !ctrl;
		e.bcast = bcast;
		e.wake = ctrl && (data[1:0] == 2'd1);
		e.sleep = ctrl && (data[1:0] == 2'd2);
		return e;
	endfunction

	// Host acknowledge, held off on request.
	always @(negedge CLK_EXT)
		rx_ack <= rx_req && !hold_ack;

	always @(negedge CLK_EXT)
	begin
		if (rx_fail)
			fail_pulses++;
		if (sleep_request_to_sleep_ctrl)
			sleep_pulses++;
		// Ring repeater, one cycle behind din.
		if (RESETn_local && !release_rst_from_sleep_ctrl)
		begin
			assert (dout === din)
				else report_mismatch("dout", 64'(din), 64'(dout));
		end
		if (!rx_req)
			req_seen = 1'b0;
		else if (!req_seen)
		begin
			req_seen = 1'b1;
			assert (exp_q.size() != 0) else report_error("rx_req rose for a hidden frame");
			exp_frame = exp_q.pop_front();
			assert ({rx_broadcast, rx_addr, rx_data} == exp_frame)
				else report_mismatch("host frame", 64'(exp_frame),
					64'({rx_broadcast, rx_addr, rx_data}));
		end
	end

	// Returns with stopped set when the bus clock no longer runs.
	task automatic wait_clkout_fall(output logic stopped);
		int n;
		logic seen_high;
		n = 0;
		seen_high = clkout;
		stopped = 1'b1;
		while (stopped && n < 8)
		begin
			@(negedge CLK_EXT);
			n++;
			if (clkout)
				seen_high = 1'b1;
			else if (seen_high)
				stopped = 1'b0;
		end
	endtask

	task automatic send_frame(input mbus_pkg::addr_t addr, input mbus_pkg::data_t data,
		input logic expect_abort);
		logic [39:0] bits;
		logic stopped;
		int n;
		int i;
		bits = {addr, data};
		@(negedge CLK_EXT);
		din <= 1'b0; // Start bit.
		n = 0;
		while (!clkout && n < 10)
		begin
			@(negedge CLK_EXT);
			n++;
		end
		assert (clkout) else report_error("bus clock did not start after the start bit");
		stopped = 1'b0;
		for (i = 39; i >= 0 && !stopped; i--)
		begin
			wait_clkout_fall(stopped);
			if (!stopped)
				din <= bits[i];
		end
		if (!stopped)
			wait_clkout_fall(stopped);
		din <= 1'b1;
		assert (stopped == expect_abort) else report_error(expect_abort ?
			"watchdog did not stop the frame" : "bus clock stopped inside a frame");
	endtask

	task automatic wait_host_req(input logic level);
		int n;
		n = 0;
		while (rx_req !== level && n < WAIT_LIMIT)
		begin
			@(negedge CLK_EXT);
			n++;
		end
		assert (rx_req === level) else report_error("timeout waiting for rx_req");
	endtask

	task automatic run_frame(input string name, input mbus_pkg::addr_t addr,
		input mbus_pkg::data_t data);
		expect_t e;
		int sleeps_before;
		int n;
		test_name = name;
		e = model_frame(addr, data);
		sleeps_before = sleep_pulses;
		if (e.visible)
			exp_q.push_back({e.bcast, addr, data});
		send_frame(addr, data, 1'b0);
		n = 0;
		while ((exp_q.size() != 0 || rx_req || rx_ack) && n < WAIT_LIMIT)
		begin
			@(negedge CLK_EXT);
			n++;
		end
		assert (n < WAIT_LIMIT) else report_error("timeout waiting for the host handshake");
		repeat (4) @(negedge CLK_EXT); // Ring idle between frames.
		if (e.wake)
			assert (layer_lines == 4'hF)
				else report_mismatch("layer lines", 64'(4'hF), 64'(layer_lines));
		if (e.sleep)
		begin
			assert (layer_lines == 4'h0)
				else report_mismatch("layer lines", 64'(4'h0), 64'(layer_lines));
			assert (sleep_pulses == sleeps_before + 1)
				else report_mismatch("sleep requests", 64'(sleeps_before + 1),
					64'(sleep_pulses));
		end
	endtask

	initial
	begin
		int i;
		int n;
		int fails_before;
		mbus_pkg::data_t data;
		mbus_pkg::data_t data_a;
		mbus_pkg::addr_t addr_a;
		RESETn_local = 1'b0;
		release_rst_from_sleep_ctrl = 1'b0;
		clkin = 1'b0;
		din = 1'b1;
		rx_ack = 1'b0;
		wakeup_proc = 1'b0;
		threshold = 8'd64; // Above a frame, watchdog quiet.
		hold_ack = 1'b0;
		req_seen = 1'b0;
		fail_pulses = 0;
		sleep_pulses = 0;
		seed = 95;
		test_name = "reset";
		repeat (3) @(posedge CLK_EXT);
		@(negedge CLK_EXT);
		RESETn_local <= 1'b1;
		repeat (4) @(negedge CLK_EXT);

		for (i = 0; i < 4; i++)
		begin
			data = $random(seed);
			run_frame($sformatf("unicast_%0d", i), {PREFIX, 4'(i + 1)}, data);
		end
		data = $random(seed);
		run_frame("unicast_other_prefix", 8'h37, data);

		data = $random(seed);
		data[1:0] = 2'b11; // No command.
		run_frame("ctrl_absorbed", 8'h00, data);
		data = $random(seed);
		run_frame("broadcast_func3", 8'h03, data);

		data = $random(seed);
		data[1:0] = 2'd1;
		run_frame("bus_wake", 8'h00, data);
		data = $random(seed);
		data[1:0] = 2'd2;
		run_frame("bus_sleep", 8'h00, data);

		test_name = "proc_power_up";
		wakeup_proc <= 1'b1;
		n = 0;
		while (!power_on_to_layer_ctrl && n < 10)
		begin
			@(posedge CLK_EXT); // Sequencer moves on falling edges.
			n++;
		end
		assert (power_on_to_layer_ctrl) else report_error("power_on never released");
		for (i = 0; i < 4; i++)
		begin
			if (i > 0)
				@(posedge CLK_EXT);
			assert (layer_lines == 4'(4'b1111 << (3 - i)))
				else report_mismatch($sformatf("layer lines step %0d", i),
					64'(4'(4'b1111 << (3 - i))), 64'(layer_lines));
		end
		@(negedge CLK_EXT);
		wakeup_proc <= 1'b0;
		n = 0;
		while (layer_lines != 4'h0 && n < 10)
		begin
			@(posedge CLK_EXT);
			n++;
		end
		assert (layer_lines == 4'h0)
			else report_mismatch("layer lines after wakeup fell", 64'(4'h0), 64'(layer_lines));

		test_name = "watchdog_abort";
		@(negedge CLK_EXT);
		threshold <= 8'd10;
		fails_before = fail_pulses;
		send_frame({PREFIX, 4'h1}, 32'h0000_00A5, 1'b1); // Leading zeros keep the ring quiet.
		repeat (6) @(negedge CLK_EXT);
		assert (fail_pulses == fails_before + 1)
			else report_mismatch("rx_fail pulses", 64'(fails_before + 1), 64'(fail_pulses));
		threshold <= 8'd64;

		test_name = "overrun";
		hold_ack <= 1'b1;
		data_a = $random(seed);
		addr_a = {PREFIX, 4'h2};
		exp_q.push_back({1'b0, addr_a, data_a});
		send_frame(addr_a, data_a, 1'b0);
		wait_host_req(1'b1);
		repeat (4) @(negedge CLK_EXT);
		fails_before = fail_pulses;
		data = $random(seed);
		send_frame({PREFIX, 4'h3}, data, 1'b0);
		repeat (4) @(negedge CLK_EXT);
		assert (fail_pulses == fails_before + 1)
			else report_mismatch("rx_fail pulses", 64'(fails_before + 1), 64'(fail_pulses));
		assert (rx_req) else report_error("held request dropped by the second frame");
		assert (rx_addr == addr_a) else report_mismatch("rx_addr", 64'(addr_a), 64'(rx_addr));
		assert (rx_data == data_a) else report_mismatch("rx_data", 64'(data_a), 64'(rx_data));
		hold_ack <= 1'b0;
		wait_host_req(1'b0);
		repeat (4) @(negedge CLK_EXT);

		test_name = "sleep_reset";
		hold_ack <= 1'b1;
		data_a = $random(seed);
		exp_q.push_back({1'b0, PREFIX, 4'h4, data_a});
		send_frame({PREFIX, 4'h4}, data_a, 1'b0);
		wait_host_req(1'b1);
		wakeup_proc <= 1'b1;
		n = 0;
		while (layer_lines != 4'hF && n < 10)
		begin
			@(posedge CLK_EXT);
			n++;
		end
		assert (layer_lines == 4'hF)
			else report_mismatch("layer lines before sleep", 64'(4'hF), 64'(layer_lines));
		@(negedge CLK_EXT);
		release_rst_from_sleep_ctrl <= 1'b1;
		wakeup_proc <= 1'b0;
		din <= 1'b0; // Ring low while held in reset.
		@(negedge CLK_EXT);
		assert (rx_req == 1'b0) else report_mismatch("rx_req", 64'(0), 64'(rx_req));
		assert (layer_lines == 4'h0)
			else report_mismatch("layer lines", 64'(4'h0), 64'(layer_lines));
		assert (dout == 1'b1) else report_mismatch("dout", 64'(1), 64'(dout));
		release_rst_from_sleep_ctrl <= 1'b0;
		din <= 1'b1;
		hold_ack <= 1'b0;
		repeat (4) @(negedge CLK_EXT);
		assert (exp_q.size() == 0) else report_error("expected host frames never arrived");

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
mbus_pkg.sv
mbus_if.sv
mbus_ctrl.sv
mbus_node.sv
ctrl_channel_filter.sv
layer_power_seq.sv
mbus_ctrl_wrapper.sv
tb_mbus_ctrl_wrapper.sv
